/* dv/dma_checker.sv */
`timescale 1ns/1ps

module dma_checker import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_cpu_request,
	input logic i_cpu_write,
	input logic [REG_ADDR_WIDTH-1:0] i_cpu_address,
	input logic [DATA_WIDTH-1:0] i_cpu_wdata,
	input logic [DATA_WIDTH-1:0] i_cpu_rdata,
	input logic i_cpu_ready,
	input logic i_bus_request,
	input logic i_bus_write,
	input logic [ADDR_WIDTH-1:0] i_bus_address,
	input logic [DATA_WIDTH-1:0] i_bus_wdata,
	input logic i_bus_ready,
	output int o_error_count,
	output int o_check_count
);
	localparam int CMD_BASE = 'h40;	// Five words per command
	localparam int EXP_BASE = 'h80;

	logic [DATA_WIDTH-1:0] stim [0:255];
	logic [64:0] txn_queue [$];	// {write, address, data}
	logic [64:0] next_txn;
	logic req_write = 1'b0;
	logic [REG_ADDR_WIDTH-1:0] req_address = '0;
	logic [DATA_WIDTH-1:0] req_wdata = '0;
	logic [DATA_WIDTH-1:0] queued_model = '0;
	logic [DATA_WIDTH-1:0] staged_count_model = '0;
	logic idle_seen = 1'b0;
	int exp_index = EXP_BASE;	// Next expected copy or feed word
	int req_cycles = 0;
	int stalled_writes = 0;	// CTRL writes held off by a full queue
	int error_count = 0;
	int check_count = 0;

	assign o_error_count = error_count;
	assign o_check_count = check_count;

	task automatic compare_word(input string name, input logic [31:0] expected_value,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected_value) begin
			error_count++;
			$display("MISMATCH %s expected %h actual %h", name, expected_value, actual);
		end
	endtask

	task automatic report_error(input string text);
		error_count++;
		$display("ERROR: %s", text);
	endtask

	// Bus sequence of one command, added once its CTRL write is accepted
	task automatic add_command_txns(input int c);
		int base;
		dma_type_t kind;
		logic [31:0] step;
		base = CMD_BASE + 5 * c;
		kind = dma_type_t'(stim[base + 1][1:0]);
		for (int k = 0; kind != NONE && k <= int'(stim[base + 4]); k++) begin
			step = 32'(WORD_BYTES * k);
			if (kind == FILL) begin
				txn_queue.push_back({1'b1, stim[base + 3] + step, stim[base + 2]});
			end else begin
				txn_queue.push_back({1'b0, stim[base + 2] + step, 32'h0});
				// Feed keeps one destination
				txn_queue.push_back({1'b1, (kind == COPY) ? stim[base + 3] + step
					: stim[base + 3], stim[exp_index]});
				exp_index++;
			end
		end
	endtask

	initial begin
		$readmemh("dv/dma_input.txt", stim);
	end

	always @(posedge i_clock) begin
		if (i_arst_n && i_bus_request && i_bus_ready) begin
			if (txn_queue.size() == 0) begin
				report_error($sformatf("unexpected bus transfer at address %h", i_bus_address));
			end else begin
				next_txn = txn_queue.pop_front();
				compare_word("o_bus_write", {31'b0, next_txn[64]}, {31'b0, i_bus_write});
				compare_word("o_bus_address", next_txn[63:32], i_bus_address);
				if (next_txn[64])
					compare_word("o_bus_wdata", next_txn[31:0], i_bus_wdata);
			end
		end

		if (i_cpu_request && !i_cpu_ready)
			req_cycles++;	// More than one means a wait
		if (i_cpu_request) begin	// Held until ready, so latch it here
			req_write = i_cpu_write;
			req_address = i_cpu_address;
			req_wdata = i_cpu_wdata;
		end
		if (i_arst_n && i_cpu_ready) begin
			if (req_write) begin
				if (req_address == REG_COUNT)
					staged_count_model = req_wdata;
				if (req_address == REG_CTRL) begin
					add_command_txns(int'(queued_model));
					queued_model = queued_model + 1;
					if (req_cycles > 1)
						stalled_writes++;
				end
			end else begin
				case (req_address)
					REG_SRC: compare_word("o_cpu_rdata(REG_SRC)", queued_model, i_cpu_rdata);
					REG_DST:
						if (idle_seen)	// Last tag is known only once idle
							compare_word("o_cpu_rdata(REG_DST)", queued_model, i_cpu_rdata);
					REG_COUNT:
						compare_word("o_cpu_rdata(REG_COUNT)", staged_count_model, i_cpu_rdata);
					default: begin
						check_count++;
						idle_seen = (i_cpu_rdata == '0);
						if (i_cpu_rdata != '0 && i_cpu_rdata != '1)
							report_error("busy flag read is neither zero nor all ones");
						else if (idle_seen && txn_queue.size() != 0)
							report_error($sformatf("engine idle with %0d bus transfers missing",
								txn_queue.size()));
						if (idle_seen && int'(queued_model) == int'(stim[0])
								&& stalled_writes == 0)
							report_error("no REG_CTRL write was held back by a full queue");
					end
				endcase
			end
			req_cycles = 0;
		end
	end

endmodule

/* dv/dma_input.txt */
// Header: command count, memory init pair count
@000
0000000A 00000007
// Memory init: byte address, word
@010
00000100 11111111
00000104 22222222
00000108 33333333
0000010C 44444444
00000200 F0000001
00000204 F0000002
00000208 F0000003
// Commands: test, type, fill value or source, destination, word count minus one
@040
00000001 00000001 CAFE0001 00000400 00000003
00000002 00000002 00000100 00000500 00000003
00000003 00000003 00000200 00000600 00000002
00000004 00000001 B0000001 00000800 0000000F
00000004 00000001 B0000002 00000840 0000000F
00000004 00000001 B0000003 00000880 0000000F
00000004 00000001 B0000004 000008C0 0000000F
00000004 00000001 B0000005 00000900 0000000F
00000004 00000001 B0000006 00000940 0000000F
00000005 00000000 00000000 00000000 00000000
// Expected copy and feed destination words in bus order
@080
11111111 22222222 33333333 44444444
F0000001 F0000002 F0000003

/* dv/dma_tb.sv */
`timescale 1ns/1ps

module dma_tb import dma_pkg::*; ();
	localparam int FIFO_DEPTH = 4;
	localparam int INIT_BASE = 'h10;	// Address and word pairs
	localparam int CMD_BASE = 'h40;
	localparam int NUM_TESTS = 5;
	localparam int MEM_WORDS = 1024;

	logic i_clock = 1'b0;
	logic i_arst_n;
	logic i_cpu_request;
	logic i_cpu_write;
	logic [REG_ADDR_WIDTH-1:0] i_cpu_address;
	logic [DATA_WIDTH-1:0] i_cpu_wdata;
	logic [DATA_WIDTH-1:0] o_cpu_rdata;
	logic o_cpu_ready;
	logic o_bus_request;
	logic o_bus_write;
	logic [ADDR_WIDTH-1:0] o_bus_address;
	logic [DATA_WIDTH-1:0] o_bus_wdata;
	logic i_bus_ready = 1'b0;
	logic [DATA_WIDTH-1:0] i_bus_rdata = '0;

	logic [DATA_WIDTH-1:0] stim [0:255];
	logic [DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];
	integer seed = 57;
	int wait_left = -1;	// No transfer pending
	int timeout_cycles = 0;
	int error_count;
	int check_count;

	always #5 i_clock = ~i_clock;

	dma_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_cpu_request(i_cpu_request), .i_cpu_write(i_cpu_write),
		.i_cpu_address(i_cpu_address), .i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata), .o_cpu_ready(o_cpu_ready),
		.o_bus_request(o_bus_request), .o_bus_write(o_bus_write),
		.o_bus_address(o_bus_address), .o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata)
	);

	dma_checker watch (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_cpu_request(i_cpu_request), .i_cpu_write(i_cpu_write),
		.i_cpu_address(i_cpu_address), .i_cpu_wdata(i_cpu_wdata),
		.i_cpu_rdata(o_cpu_rdata), .i_cpu_ready(o_cpu_ready),
		.i_bus_request(o_bus_request), .i_bus_write(o_bus_write),
		.i_bus_address(o_bus_address), .i_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.o_error_count(error_count), .o_check_count(check_count)
	);

	// Memory behind the bus with 0 to 3 wait cycles
	always @(negedge i_clock) begin
		if (!i_arst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] = 32'hC0DE_0000 ^ 32'(i * WORD_BYTES);	// Byte address in the word
			for (int i = 0; i < int'(stim[1]); i++)
				mem[stim[INIT_BASE + 2 * i][11:2]] = stim[INIT_BASE + 2 * i + 1];
			i_bus_ready <= 1'b0;
			wait_left = -1;
		end else if (i_bus_ready) begin
			i_bus_ready <= 1'b0;	// Transfer ended at the last rising edge
			wait_left = -1;
		end else if (o_bus_request) begin
			if (wait_left < 0)
				wait_left = $random(seed) & 3;
			if (wait_left == 0) begin
				if (o_bus_write)
					mem[o_bus_address[11:2]] = o_bus_wdata;
				else
					i_bus_rdata <= mem[o_bus_address[11:2]];
				i_bus_ready <= 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	function automatic string test_name(input int t);
		case (t)
			1: return "fill";
			2: return "copy";
			3: return "feed";
			4: return "queue order";
			default: return "null command";
		endcase
	endfunction

	task automatic cpu_access(input logic write, input logic [REG_ADDR_WIDTH-1:0] address,
			input logic [DATA_WIDTH-1:0] wdata, output logic [DATA_WIDTH-1:0] rdata);
		@(negedge i_clock);
		i_cpu_request = 1'b1;
		i_cpu_write = write;
		i_cpu_address = address;
		i_cpu_wdata = wdata;
		do
			@(negedge i_clock);
		while (!o_cpu_ready);
		rdata = o_cpu_rdata;
		i_cpu_request = 1'b0;
	endtask

	task automatic queue_command(input int base);
		logic [DATA_WIDTH-1:0] unused_rdata;
		cpu_access(1'b1, REG_SRC, stim[base + 2], unused_rdata);
		cpu_access(1'b1, REG_DST, stim[base + 3], unused_rdata);
		cpu_access(1'b1, REG_COUNT, stim[base + 4], unused_rdata);
		cpu_access(1'b1, REG_CTRL, stim[base + 1], unused_rdata);	// Type queues it
	endtask

	initial begin
		int cmd;
		int words;
		int errors_before;
		logic [DATA_WIDTH-1:0] rdata;
		i_arst_n = 1'b0;
		i_cpu_request = 1'b0;
		i_cpu_write = 1'b0;
		i_cpu_address = '0;
		i_cpu_wdata = '0;
		$readmemh("dv/dma_input.txt", stim);
		words = 0;
		for (int c = 0; c < int'(stim[0]); c++)
			words += int'(stim[CMD_BASE + 5 * c + 4]) + 1;
		timeout_cycles = 200 * words + 1000;
		repeat (5) @(posedge i_clock);
		@(negedge i_clock);
		i_arst_n = 1'b1;

		cmd = 0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			errors_before = error_count;
			while (cmd < int'(stim[0]) && int'(stim[CMD_BASE + 5 * cmd]) == t) begin
				queue_command(CMD_BASE + 5 * cmd);
				cmd++;
			end
			cpu_access(1'b0, REG_SRC, '0, rdata);
			cpu_access(1'b0, REG_COUNT, '0, rdata);
			do
				cpu_access(1'b0, REG_CTRL, '0, rdata);
			while (rdata != '0);
			cpu_access(1'b0, REG_DST, '0, rdata);
			$display("test %0d %s: %0d errors", t, test_name(t), error_count - errors_before);
		end
		$display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count,
			error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge i_clock);
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module dma_tb -f sources.f -o dma_sim
./obj_dir/dma_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

/* sources.f */
src/dma_pkg.sv
src/dma_cmd_fifo.sv
src/dma_regs.sv
src/dma_engine.sv
src/dma_top.sv
dv/dma_checker.sv
dv/dma_tb.sv

/* src/dma_cmd_fifo.sv */
`timescale 1ns/1ps

module dma_cmd_fifo import dma_pkg::*; #(
	parameter int DEPTH = 4,
	parameter type T = dma_cmd_t
) (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_push_valid,
	input T i_push_data,
	output logic o_push_ready,
	output logic o_pop_valid,
	output T o_pop_data,
	input logic i_pop_ready
);
	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic push_fire;
	logic pop_fire;

	// Wraps at DEPTH so non power of two depths work
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_push_ready = (count != CNT_WIDTH'(DEPTH));
	assign o_pop_valid = (count != '0);
	assign o_pop_data = mem[rd_ptr];	// Show-ahead head
	assign push_fire = i_push_valid && o_push_ready;
	assign pop_fire = i_pop_ready && o_pop_valid;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_fire)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push_fire, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push_fire)
			mem[wr_ptr] <= i_push_data;
	end

	// A full queue without a pop must keep its write pointer and stay full
	a_no_push_when_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(count == CNT_WIDTH'(DEPTH) && !pop_fire)
		|=> (count == CNT_WIDTH'(DEPTH) && $stable(wr_ptr)));

endmodule

/* src/dma_engine.sv */
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_cmd_valid,
	input dma_cmd_t i_cmd,
	output logic o_cmd_ready,

	output logic o_busy,
	output logic o_retire_valid,
	output logic [DATA_WIDTH-1:0] o_retire_tag,

	output logic o_bus_request,
	output logic o_bus_write,
	output logic [ADDR_WIDTH-1:0] o_bus_address,
	output logic [DATA_WIDTH-1:0] o_bus_wdata,
	input logic i_bus_ready,
	input logic [DATA_WIDTH-1:0] i_bus_rdata
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_FILL_WRITE,
		S_READ,
		S_WRITE,
		S_FINISH
	} state_t;

	state_t state;

	// Working copy of the popped command
	dma_type_t cur_kind;
	logic [DATA_WIDTH-1:0] value_or_src;
	logic [ADDR_WIDTH-1:0] dst;
	logic [DATA_WIDTH-1:0] count;
	logic [DATA_WIDTH-1:0] tag;
	logic [DATA_WIDTH-1:0] read_data;

	logic cmd_pop;
	logic bus_state;
	logic bus_issue;
	logic bus_done;
	logic last_word;

	assign o_cmd_ready = (state == S_IDLE);
	assign cmd_pop = o_cmd_ready && i_cmd_valid;
	assign bus_state = (state == S_FILL_WRITE) || (state == S_READ) || (state == S_WRITE);
	// Request low in a bus state means the idle cycle before the next transfer
	assign bus_issue = bus_state && !o_bus_request;
	assign bus_done = o_bus_request && i_bus_ready;
	assign last_word = (count == '0);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= S_IDLE;
			o_bus_request <= 1'b0;
			o_busy <= 1'b0;
			o_retire_valid <= 1'b0;
		end else begin
			o_retire_valid <= 1'b0;
			if (bus_issue)
				o_bus_request <= 1'b1;
			else if (bus_done)
				o_bus_request <= 1'b0;

			case (state)
				S_IDLE: begin
					o_busy <= cmd_pop;	// Stays high through the retire pulse
					if (cmd_pop) begin
						case (i_cmd.kind)
							FILL: state <= S_FILL_WRITE;
							COPY, FEED: state <= S_READ;
							default: state <= S_FINISH;	// NONE
						endcase
					end
				end
				S_FILL_WRITE:
					if (bus_done && last_word)
						state <= S_FINISH;
				S_READ:
					if (bus_done)
						state <= S_WRITE;
				S_WRITE:
					if (bus_done)
						state <= last_word ? S_FINISH : S_READ;
				S_FINISH: begin
					o_retire_valid <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (cmd_pop) begin
			cur_kind <= i_cmd.kind;
			value_or_src <= i_cmd.value_or_src;
			dst <= i_cmd.dst;
			count <= i_cmd.count;
			tag <= i_cmd.tag;
		end

		if (bus_issue) begin
			o_bus_write <= (state != S_READ);
			o_bus_address <= (state == S_READ) ? value_or_src : dst;
			o_bus_wdata <= (state == S_FILL_WRITE) ? value_or_src : read_data;
		end

		if (bus_done) begin
			case (state)
				S_FILL_WRITE: begin
					dst <= dst + ADDR_WIDTH'(WORD_BYTES);
					count <= count - 1'b1;	// Wraps on the last word, unused then
				end
				S_READ: begin
					read_data <= i_bus_rdata;
					value_or_src <= value_or_src + DATA_WIDTH'(WORD_BYTES);
				end
				S_WRITE: begin
					if (cur_kind == COPY)
						dst <= dst + ADDR_WIDTH'(WORD_BYTES);	// Feed keeps dst fixed
					count <= count - 1'b1;
				end
				default: ;
			endcase
		end

		if (state == S_FINISH)
			o_retire_tag <= tag;
	end

	// Request and fields held until the memory answers
	a_bus_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(o_bus_request && !i_bus_ready)
		|=> (o_bus_request && $stable(o_bus_write) && $stable(o_bus_address)
			&& $stable(o_bus_wdata)));

endmodule

/* src/dma_pkg.sv */
package dma_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_BYTES = 4;		// Address step per word
	localparam int REG_ADDR_WIDTH = 2;

	// Register map, the read meaning differs from the write meaning
	localparam logic [REG_ADDR_WIDTH-1:0] REG_SRC = 2'd0;		// Reads queued counter
	localparam logic [REG_ADDR_WIDTH-1:0] REG_DST = 2'd1;		// Reads retired counter
	localparam logic [REG_ADDR_WIDTH-1:0] REG_COUNT = 2'd2;	// Reads staged count
	localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL = 2'd3;		// Reads busy flag

	typedef enum logic [1:0] {
		NONE = 2'd0,
		FILL = 2'd1,
		COPY = 2'd2,
		FEED = 2'd3
	} dma_type_t;

	// Count holds words minus one
	typedef struct packed {
		dma_type_t kind;
		logic [DATA_WIDTH-1:0] value_or_src;
		logic [ADDR_WIDTH-1:0] dst;
		logic [DATA_WIDTH-1:0] count;
		logic [DATA_WIDTH-1:0] tag;
	} dma_cmd_t;

endpackage

/* src/dma_regs.sv */
`timescale 1ns/1ps

module dma_regs import dma_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_cpu_request,
	input logic i_cpu_write,
	input logic [REG_ADDR_WIDTH-1:0] i_cpu_address,
	input logic [DATA_WIDTH-1:0] i_cpu_wdata,
	output logic [DATA_WIDTH-1:0] o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_queue_valid,
	output dma_cmd_t o_queue_cmd,
	input logic i_queue_ready,
	input logic i_queue_nonempty,

	input logic i_busy,
	input logic i_retire_valid,
	input logic [DATA_WIDTH-1:0] i_retire_tag
);
	logic [DATA_WIDTH-1:0] staged_src;
	logic [ADDR_WIDTH-1:0] staged_dst;
	logic [DATA_WIDTH-1:0] staged_count;
	logic [DATA_WIDTH-1:0] queued_count;
	logic [DATA_WIDTH-1:0] retired_count;
	logic [DATA_WIDTH-1:0] read_value;
	logic access_start;
	logic ctrl_write;
	logic push_fire;

	// A new access is one not yet answered
	assign access_start = i_cpu_request && !o_cpu_ready;
	assign ctrl_write = i_cpu_write && (i_cpu_address == REG_CTRL);

	// Push valid holds for as long as the CTRL write waits on a full queue
	assign o_queue_valid = access_start && ctrl_write;
	assign push_fire = o_queue_valid && i_queue_ready;

	always_comb begin
		o_queue_cmd.kind = dma_type_t'(i_cpu_wdata[1:0]);
		o_queue_cmd.value_or_src = staged_src;
		o_queue_cmd.dst = staged_dst;
		o_queue_cmd.count = staged_count;
		o_queue_cmd.tag = queued_count + 1'b1;	// Tags start at one
	end

	always_comb begin
		case (i_cpu_address)
			REG_SRC: read_value = queued_count;
			REG_DST: read_value = retired_count;
			REG_COUNT: read_value = staged_count;
			default: read_value = (i_busy || i_queue_nonempty) ? '1 : '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_cpu_ready <= 1'b0;
			queued_count <= '0;
			retired_count <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			if (i_retire_valid)
				retired_count <= i_retire_tag;
			if (push_fire) begin
				queued_count <= queued_count + 1'b1;
				o_cpu_ready <= 1'b1;
			end else if (access_start && !ctrl_write) begin
				o_cpu_ready <= 1'b1;	// Plain access, one cycle
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access_start && i_cpu_write) begin
			case (i_cpu_address)
				REG_SRC: staged_src <= i_cpu_wdata;
				REG_DST: staged_dst <= i_cpu_wdata;
				REG_COUNT: staged_count <= i_cpu_wdata;
				default: ;	// CTRL goes to the queue
			endcase
		end
		if (access_start && !i_cpu_write)
			o_cpu_rdata <= read_value;
	end

	a_ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		$rose(o_cpu_ready) |-> $past(i_cpu_request));

endmodule

/* src/dma_top.sv */
`timescale 1ns/1ps

module dma_top import dma_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic i_clock,
	input logic i_arst_n,

	input logic i_cpu_request,
	input logic i_cpu_write,
	input logic [REG_ADDR_WIDTH-1:0] i_cpu_address,
	input logic [DATA_WIDTH-1:0] i_cpu_wdata,
	output logic [DATA_WIDTH-1:0] o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_bus_request,
	output logic o_bus_write,
	output logic [ADDR_WIDTH-1:0] o_bus_address,
	output logic [DATA_WIDTH-1:0] o_bus_wdata,
	input logic i_bus_ready,
	input logic [DATA_WIDTH-1:0] i_bus_rdata
);
	logic push_valid;
	logic push_ready;
	dma_cmd_t push_cmd;
	logic pop_valid;
	logic pop_ready;
	dma_cmd_t pop_cmd;
	logic busy;
	logic retire_valid;
	logic [DATA_WIDTH-1:0] retire_tag;

	dma_regs u_regs (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_write(i_cpu_write),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_queue_valid(push_valid),
		.o_queue_cmd(push_cmd),
		.i_queue_ready(push_ready),
		.i_queue_nonempty(pop_valid),	// Pop valid doubles as not empty
		.i_busy(busy),
		.i_retire_valid(retire_valid),
		.i_retire_tag(retire_tag)
	);

	dma_cmd_fifo #(
		.DEPTH(FIFO_DEPTH),
		.T(dma_cmd_t)
	) u_queue (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_push_valid(push_valid),
		.i_push_data(push_cmd),
		.o_push_ready(push_ready),
		.o_pop_valid(pop_valid),
		.o_pop_data(pop_cmd),
		.i_pop_ready(pop_ready)
	);

	dma_engine u_engine (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_cmd_valid(pop_valid),
		.i_cmd(pop_cmd),
		.o_cmd_ready(pop_ready),
		.o_busy(busy),
		.o_retire_valid(retire_valid),
		.o_retire_tag(retire_tag),
		.o_bus_request(o_bus_request),
		.o_bus_write(o_bus_write),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule
